//--- verilog/imul_config.svh
// multiply unit configuration
// lane count, operand width and iteration count shared by all blocks

`ifndef IMUL_CONFIG_SVH
`define IMUL_CONFIG_SVH

// number of parallel multiplier lanes, 2 or more
`define IMUL_NUM_LANES 4

// operand width in bits, product is twice this
`define IMUL_XLEN 32

// shift-and-add steps per multiply, one per multiplier bit
`define IMUL_ITERS `IMUL_XLEN

`endif

//--- verilog/imul_pkg.sv
// multiply unit package
// operation encoding, operand/product words and lane index type

`include "imul_config.svh"

package imul_pkg;

  // operation select carried with each request
  typedef enum logic {
    IMUL_OP_SIGNED   = 1'b0,
    IMUL_OP_UNSIGNED = 1'b1
  } imul_op_t;

  // source operand word
  typedef logic [`IMUL_XLEN-1:0] operand_t;

  // full-width product word
  typedef logic [2*`IMUL_XLEN-1:0] product_t;

  // names one lane in the array, used by dispatch and collect pointers
  typedef logic [$clog2(`IMUL_NUM_LANES)-1:0] lane_idx_t;

endpackage

//--- verilog/imul_req_if.sv
// multiply request channel
// valid/ready handshake with two operands and the operation bit

`timescale 1ns/1ps

`include "imul_config.svh"

interface imul_req_if
  import imul_pkg::*;
;

  // handshake pair, transfer on a rising edge with both high
  logic     val;
  logic     rdy;

  // payload, held steady by the sender from val rise until transfer
  operand_t a;
  operand_t b;
  imul_op_t op;

  // dispatcher side
  modport sender (
    output val,
    output a,
    output b,
    output op,
    input  rdy
  );

  // lane side
  modport receiver (
    input  val,
    input  a,
    input  b,
    input  op,
    output rdy
  );

endinterface

//--- verilog/imul_dispatch.sv
// round-robin request dispatcher
// steers each top-level request to the lane named by the issue pointer

`timescale 1ns/1ps

`include "imul_config.svh"

module imul_dispatch
  import imul_pkg::*;
(
  input  logic           clk,
  input  logic           reset,

  // top-level request port
  input  logic           req_val,
  input  operand_t       req_a,
  input  operand_t       req_b,
  input  imul_op_t       req_op,
  output logic           req_rdy,

  // one request channel per lane
  imul_req_if.sender     lanes [`IMUL_NUM_LANES]
);

  // --------------------------------------------------------------------------
  // issue pointer
  // --------------------------------------------------------------------------

  // lane that gets the next request
  lane_idx_t                  ptr;

  // per-lane copies of the handshake, gathered for indexing
  logic [`IMUL_NUM_LANES-1:0] lane_val;
  logic [`IMUL_NUM_LANES-1:0] lane_rdy;

  logic                       xfer;

  assign xfer = req_val && req_rdy;

  // wrap explicitly so a lane count that is not a power of two works
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (xfer) begin
      if (ptr == lane_idx_t'(`IMUL_NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // steering
  // --------------------------------------------------------------------------

  // interface array elements need a constant index, hence the loop
  for (genvar i = 0; i < `IMUL_NUM_LANES; i++) begin : g_lane
    // only the pointed lane sees val
    assign lane_val[i]  = req_val && (ptr == lane_idx_t'(i));
    assign lanes[i].val = lane_val[i];
    // payload goes to every lane, harmless without val
    assign lanes[i].a   = req_a;
    assign lanes[i].b   = req_b;
    assign lanes[i].op  = req_op;
    assign lane_rdy[i]  = lanes[i].rdy;
  end

  // stall the port until the pointed lane is idle again
  assign req_rdy = lane_rdy[ptr];

  // a stalled request stays offered, unchanged, until the pointed lane takes it
  a_req_hold : assert property (
    @(posedge clk) disable iff (reset)
    req_val && !req_rdy |=>
      req_val && $stable(req_a) && $stable(req_b) && $stable(req_op)
  );

endmodule

//--- verilog/imul_lane.sv
// iterative shift-and-add multiplier lane
// one load cycle, 32 add/shift steps, a sign fix step, then holds the product

`timescale 1ns/1ps

`include "imul_config.svh"

module imul_lane
  import imul_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // request from the dispatcher
  imul_req_if.receiver req,

  // response to the collector
  output logic         resp_val,
  output product_t     resp_result,
  input  logic         resp_rdy
);

  localparam int CNT_W = $clog2(`IMUL_ITERS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_DONE
  } state_t;

  // --------------------------------------------------------------------------
  // control state
  // --------------------------------------------------------------------------

  state_t           state;
  // steps left, counts down to zero on the last add/shift
  logic [CNT_W-1:0] count;
  // set for the one cycle after the last step, when the sign is applied
  logic             sign_fix;

  // datapath registers
  product_t         mcand;
  operand_t         mplier;
  product_t         acc;
  logic             negate;

  logic             accept;
  logic             deliver;
  logic             signed_op;
  operand_t         mag_a;
  operand_t         mag_b;
  product_t         acc_next;

  assign accept  = req.val && req.rdy;
  assign deliver = resp_val && resp_rdy;

  // --------------------------------------------------------------------------
  // operand conditioning
  // --------------------------------------------------------------------------

  assign signed_op = (req.op == IMUL_OP_SIGNED);

  // strip signs for a signed op, unsigned op passes operands through
  // most negative value maps to 2^(xlen-1), which is still right unsigned
  assign mag_a = (signed_op && req.a[`IMUL_XLEN-1]) ? ~req.a + 1'b1 : req.a;
  assign mag_b = (signed_op && req.b[`IMUL_XLEN-1]) ? ~req.b + 1'b1 : req.b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = mplier[0] ? acc + mcand : acc;

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      count    <= '0;
      sign_fix <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state    <= ST_CALC;
            count    <= CNT_W'(`IMUL_ITERS - 1);
            sign_fix <= 1'b0;
          end
        end
        ST_CALC: begin
          if (sign_fix) begin
            // product is final after this edge
            state    <= ST_DONE;
            sign_fix <= 1'b0;
          end else if (count == '0) begin
            sign_fix <= 1'b1;
          end else begin
            count <= count - 1'b1;
          end
        end
        ST_DONE: begin
          // hold until the collector takes the result
          if (deliver) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= product_t'(mag_a);
      mplier <= mag_b;
      acc    <= '0;
      // result negative only if exactly one signed operand is negative
      negate <= signed_op && (req.a[`IMUL_XLEN-1] ^ req.b[`IMUL_XLEN-1]);
    end else if (state == ST_CALC) begin
      if (sign_fix) begin
        if (negate) begin
          acc <= ~acc + 1'b1;
        end
      end else begin
        acc    <= acc_next;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

  // only idle lanes take work
  assign req.rdy     = (state == ST_IDLE);
  assign resp_val    = (state == ST_DONE);
  assign resp_result = acc;

  // result is held unchanged until the collector takes it
  a_resp_hold : assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result)
  );

  // busy for the whole multiply, response exactly 33 edges after accept
  a_busy_window : assert property (
    @(posedge clk) disable iff (reset)
    accept |=> !req.rdy [*33] ##1 (resp_val && !req.rdy)
  );

endmodule

//--- verilog/imul_collect.sv
// round-robin response collector
// drains lanes in dispatch order so products leave in request order

`timescale 1ns/1ps

`include "imul_config.svh"

module imul_collect
  import imul_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,

  // lane responses
  input  logic [`IMUL_NUM_LANES-1:0] lane_val,
  input  product_t                   lane_result [`IMUL_NUM_LANES],
  output logic [`IMUL_NUM_LANES-1:0] lane_rdy,

  // top-level response port
  output logic                       resp_val,
  output product_t                   resp_result,
  input  logic                       resp_rdy
);

  // --------------------------------------------------------------------------
  // drain pointer
  // --------------------------------------------------------------------------

  // lane whose result leaves next, trails the dispatch pointer
  lane_idx_t ptr;
  logic      xfer;

  assign xfer = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (xfer) begin
      if (ptr == lane_idx_t'(`IMUL_NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // output mux
  // --------------------------------------------------------------------------

  // a later lane that finishes early just waits for its turn
  assign resp_val    = lane_val[ptr];
  assign resp_result = lane_result[ptr];

  // ready goes back to the pointed lane only
  always_comb begin
    for (int i = 0; i < `IMUL_NUM_LANES; i++) begin
      lane_rdy[i] = resp_rdy && (ptr == lane_idx_t'(i));
    end
  end

  // a stalled output must not change under the consumer
  a_result_stable : assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result)
  );

endmodule

//--- verilog/imul_array.sv
// multi-lane multiply unit, top level
// dispatcher, parallel iterative lanes and in-order collector

`timescale 1ns/1ps

`include "imul_config.svh"

module imul_array
  import imul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // request port
  input  logic     req_val,
  input  operand_t req_a,
  input  operand_t req_b,
  input  imul_op_t req_op,
  output logic     req_rdy,

  // response port
  output logic     resp_val,
  output product_t resp_result,
  input  logic     resp_rdy
);

  // --------------------------------------------------------------------------
  // lane request channels and response wires
  // --------------------------------------------------------------------------

  imul_req_if                 lane_req [`IMUL_NUM_LANES] ();

  logic [`IMUL_NUM_LANES-1:0] lane_val;
  product_t                   lane_result [`IMUL_NUM_LANES];
  logic [`IMUL_NUM_LANES-1:0] lane_rdy;

  // round-robin issue to the lanes
  imul_dispatch dispatch (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_a   (req_a),
    .req_b   (req_b),
    .req_op  (req_op),
    .req_rdy (req_rdy),
    .lanes   (lane_req)
  );

  // --------------------------------------------------------------------------
  // lanes
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < `IMUL_NUM_LANES; i++) begin : g_lane
    imul_lane lane (
      .clk         (clk),
      .reset       (reset),
      .req         (lane_req[i]),
      .resp_val    (lane_val[i]),
      .resp_result (lane_result[i]),
      .resp_rdy    (lane_rdy[i])
    );
  end

  // drain in the same order as issue
  imul_collect collect (
    .clk         (clk),
    .reset       (reset),
    .lane_val    (lane_val),
    .lane_result (lane_result),
    .lane_rdy    (lane_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy)
  );

endmodule

//--- verification/imul_array_tb.sv
// multiply unit testbench
// random and corner requests against a reference model, stalls and latency checks

`timescale 1ns/1ps

`include "imul_config.svh"

module imul_array_tb
  import imul_pkg::*;
;

  localparam int CLK_PERIOD     = 40;
  localparam int N_SIGNED       = 200;
  localparam int N_UNSIGNED     = 100;
  localparam int N_CORNER       = 32;
  localparam int N_BACKPRESSURE = 200;
  // latency, fill and fill release each add requests of their own
  localparam int TOTAL_REQS = 1 + N_SIGNED + N_UNSIGNED + N_CORNER + `IMUL_NUM_LANES + 1
                              + N_BACKPRESSURE;
  // every request given a full serial multiply, plus reset and hold cycles
  localparam longint WATCHDOG_NS = longint'(TOTAL_REQS) * (`IMUL_ITERS + 2) * CLK_PERIOD
                                   + 200 * CLK_PERIOD;

  logic     clk;
  logic     reset;
  logic     req_val;
  operand_t req_a;
  operand_t req_b;
  imul_op_t req_op;
  logic     req_rdy;
  logic     resp_val;
  product_t resp_result;
  logic     resp_rdy;

  integer      seed = 32'h0e797c76;
  // 0 always ready, 1 random stalls, 2 held low
  int          stall_mode;
  logic [31:0] stall_draw;
  string       test_name;
  product_t    model_q [$];
  product_t    expected;
  int          n;

  imul_array uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .req_rdy     (req_rdy),
    .resp_val    (resp_val),
    .resp_result (resp_result),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input product_t exp, input product_t act);
    if (exp !== act) begin
      fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // full-width product straight from the operand values
  function automatic product_t model_product(input operand_t a, input operand_t b,
                                             input imul_op_t op);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    sa = {{`IMUL_XLEN{a[`IMUL_XLEN-1]}}, a};
    sb = {{`IMUL_XLEN{b[`IMUL_XLEN-1]}}, b};
    ua = {{`IMUL_XLEN{1'b0}}, a};
    ub = {{`IMUL_XLEN{1'b0}}, b};
    if (op == IMUL_OP_SIGNED) begin
      return product_t'(sa * sb);
    end else begin
      return product_t'(ua * ub);
    end
  endfunction

  function automatic operand_t rand_word();
    return $random(seed);
  endfunction

  function automatic imul_op_t rand_op();
    logic [31:0] r;
    r = $random(seed);
    return r[0] ? IMUL_OP_UNSIGNED : IMUL_OP_SIGNED;
  endfunction

  // zero, one, all-ones and most negative
  function automatic operand_t corner_value(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic send_req(input operand_t a, input operand_t b, input imul_op_t op);
    req_val = 1'b1;
    req_a   = a;
    req_b   = b;
    req_op  = op;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #2;
    req_val = 1'b0;
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  // outputs checked on every cycle of reset
  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) begin
      @(posedge clk);
      #2;
      check_value("reset_state", '0, product_t'(resp_val));
      check_value("reset_state", 1, product_t'(req_rdy));
    end
    reset = 1'b0;
    @(negedge clk);
    check_value("reset_state", '0, product_t'(resp_val));
    check_value("reset_state", 1, product_t'(req_rdy));
    @(posedge clk);
    #2;
  endtask

  // ------------------------------------------------------------------------
  // monitor and response ready
  // ------------------------------------------------------------------------

  // inputs only move 2 ns after a rising edge, so the falling edge shows
  // exactly what the next rising edge transfers
  always @(negedge clk) begin
    if (!reset) begin
      if (req_val && req_rdy) begin
        model_q.push_back(model_product(req_a, req_b, req_op));
      end
      if (resp_val && resp_rdy) begin
        if (model_q.size() == 0) begin
          fail_run("response delivered with no request outstanding");
        end else begin
          expected = model_q.pop_front();
          check_value(test_name, expected, resp_result);
        end
      end
    end
  end

  // draw at the falling edge, apply after the rising edge
  initial begin
    forever begin
      @(negedge clk);
      stall_draw = $random(seed);
      @(posedge clk);
      #2;
      case (stall_mode)
        0:       resp_rdy = 1'b1;
        1:       resp_rdy = (stall_draw[1:0] != 2'b00);
        default: resp_rdy = 1'b0;
      endcase
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog timeout, the DUT stopped delivering results");
  end

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------

  initial begin
    reset      = 1'b1;
    req_val    = 1'b0;
    req_a      = '0;
    req_b      = '0;
    req_op     = IMUL_OP_SIGNED;
    resp_rdy   = 1'b1;
    stall_mode = 0;
    test_name  = "reset_state";
    apply_reset();

    // idle lanes, so dispatch and collect add nothing to the lane latency
    test_name = "first_result_latency";
    send_req(32'hffff_fffd, 32'h0000_0007, IMUL_OP_SIGNED);
    n = 0;
    while (!resp_val && n < 64) begin
      @(posedge clk);
      #1;
      n++;
    end
    check_value(test_name, product_t'(`IMUL_ITERS + 1), product_t'(n));
    #1;
    wait_drain();

    test_name = "signed_random";
    for (int i = 0; i < N_SIGNED; i++) begin
      send_req(rand_word(), rand_word(), IMUL_OP_SIGNED);
    end
    wait_drain();

    test_name = "unsigned_and_corners";
    for (int i = 0; i < N_UNSIGNED; i++) begin
      send_req(rand_word(), rand_word(), IMUL_OP_UNSIGNED);
    end
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        send_req(corner_value(i), corner_value(j), IMUL_OP_SIGNED);
        send_req(corner_value(i), corner_value(j), IMUL_OP_UNSIGNED);
      end
    end
    wait_drain();

    // every lane takes one request back to back, then the port stalls
    test_name  = "lane_fill";
    stall_mode = 2;
    apply_reset();
    for (int i = 0; i < `IMUL_NUM_LANES; i++) begin
      req_val = 1'b1;
      req_a   = rand_word();
      req_b   = rand_word();
      req_op  = rand_op();
      @(negedge clk);
      check_value(test_name, 1, product_t'(req_rdy));
      @(posedge clk);
      #2;
    end
    req_a  = rand_word();
    req_b  = rand_word();
    req_op = rand_op();
    repeat (2 * (`IMUL_ITERS + 4)) begin
      @(negedge clk);
      check_value(test_name, '0, product_t'(req_rdy));
    end
    stall_mode = 0;
    do @(negedge clk); while (!req_rdy);
    @(posedge clk);
    #2;
    req_val = 1'b0;
    wait_drain();

    test_name  = "backpressure_order";
    stall_mode = 1;
    for (int i = 0; i < N_BACKPRESSURE; i++) begin
      idle_cycles({$random(seed)} % 4);
      send_req(rand_word(), rand_word(), rand_op());
    end
    wait_drain();

    idle_cycles(4);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/imul_pkg.sv
verilog/imul_req_if.sv
verilog/imul_dispatch.sv
verilog/imul_lane.sv
verilog/imul_collect.sv
verilog/imul_array.sv
verification/imul_array_tb.sv

//--- Makefile
# Verilator build and run for the multi-lane multiply unit

VERILATOR ?= verilator
TOP       ?= imul_array_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

# sources come from the file list, headers from the RTL folder
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail is taken from the log, not from the exit status
run: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "Testbench passed" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
